//--- common/stepper_pkg.sv
package stepper_pkg;

  // Host command codes, top byte of a header word
  localparam logic [7:0] cmd_coordinated_step = 8'h01;
  localparam logic [7:0] cmd_clk_divisor      = 8'h03;
  localparam logic [7:0] cmd_motor_enable     = 8'h0a;
  localparam logic [7:0] cmd_api_version      = 8'hfe;

  // Version reply, bytes 0 to 3
  localparam logic [7:0] version_patch = 8'd4;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_devel = 8'd0;

  localparam logic [7:0] default_clock_divisor = 8'd40; // DDA tick divisor after reset

  // Header word layout
  localparam int hdr_msb    = 63; // Command byte ends here
  localparam int axis_field = 48; // Low bit of the axis byte, also payload width

  // Header view of a received word
  typedef struct packed {
    logic [7:0]            cmd;
    logic [7:0]            axis;    // Not used by any command here
    logic [axis_field-1:0] payload; // Direction, enable or divisor in low bits
  } rx_hdr_t;

  // One received word, seen as a header or as a raw argument
  typedef union packed {
    rx_hdr_t          hdr;
    logic [hdr_msb:0] raw;
  } rx_word_u;

  // Increment and increment-increment, 32 fraction bits
  typedef logic signed [63:0] dda_word_t;

endpackage

//--- common/move_wr_if.sv
// Decoder side of the move buffer
interface move_wr_if;

  logic        dir_wr;    // Write direction bits of current slot
  logic        dur_wr;    // Write duration
  logic        inc_wr;    // Write increment of axis
  logic        incinc_wr; // Write increment-increment of axis
  logic [7:0]  axis;
  logic [63:0] wdata;
  logic        commit;    // Slot complete, hand it to the DDA side

  modport decoder (
    output dir_wr, dur_wr, inc_wr, incinc_wr,
    output axis, wdata, commit
  );

  modport buffer (
    input dir_wr, dur_wr, inc_wr, incinc_wr,
    input axis, wdata, commit
  );

endinterface

//--- common/move_rd_if.sv
// DDA side of the move buffer
interface move_rd_if #(
  parameter int motor_count        = 2,
  parameter int move_duration_bits = 32
);

  logic [1:0]                    pending;  // One bit per slot
  logic [move_duration_bits-1:0] duration; // All of these are for slot rd_slot
  logic [motor_count-1:0]        dir;
  stepper_pkg::dda_word_t        increment [motor_count];
  stepper_pkg::dda_word_t        incinc    [motor_count];

  logic rd_slot;
  logic slot_release; // One cycle, frees slot rd_slot

  modport buffer (
    output pending, duration, dir, increment, incinc,
    input  rd_slot, slot_release
  );

  modport sequencer (
    input  pending, duration,
    output rd_slot, slot_release
  );

  modport timer (input increment, incinc);

endinterface

//--- src/spi_cmd_decoder.sv
module spi_cmd_decoder #(
  parameter int motor_count = 2
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic [63:0]            word_data_received,
  input  logic                   word_received,
  output logic [63:0]            word_send_data,
  output logic [motor_count-1:0] enable,
  output logic [7:0]             clock_divisor,
  move_wr_if.decoder             wr
);

  // Duration word, then increment and incinc per axis
  localparam int last_word = 1 + 2 * motor_count;

  stepper_pkg::rx_word_u rx;
  logic [1:0]            word_received_r;
  logic                  word_strobe;
  logic [7:0]            message_header;
  logic [7:0]            message_word_count;
  logic [7:0]            axis_index;
  logic                  awaiting_more_words;

  assign rx          = word_data_received;
  assign word_strobe = (word_received_r == 2'b01); // Rising edge of the SPI strobe
  assign axis_index  = (message_word_count >> 1) - 8'd1; // Words 2k and 2k+1 go to axis k-1

  // Header still open, next word is a follow-on
  assign awaiting_more_words = (message_header == stepper_pkg::cmd_coordinated_step) ||
                               (message_header == stepper_pkg::cmd_api_version);

  // Argument path to the buffer, strobes below say where it goes
  always_ff @(posedge CLK) begin
    if (word_strobe) begin
      wr.wdata <= rx.raw;
      wr.axis  <= axis_index;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_r    <= 2'b00;
      word_send_data     <= '0;
      enable             <= '0;
      clock_divisor      <= stepper_pkg::default_clock_divisor;
      message_header     <= '0;
      message_word_count <= '0;
      wr.dir_wr          <= 1'b0;
      wr.dur_wr          <= 1'b0;
      wr.inc_wr          <= 1'b0;
      wr.incinc_wr       <= 1'b0;
      wr.commit          <= 1'b0;
    end else begin
      word_received_r <= {word_received_r[0], word_received};
      wr.dir_wr       <= 1'b0;
      wr.dur_wr       <= 1'b0;
      wr.inc_wr       <= 1'b0;
      wr.incinc_wr    <= 1'b0;
      wr.commit       <= 1'b0;

      if (word_strobe) begin
        word_send_data <= '0;
        if (!awaiting_more_words) begin
          // New header
          message_header     <= rx.hdr.cmd;
          message_word_count <= 8'd1;
          case (rx.hdr.cmd)
            stepper_pkg::cmd_coordinated_step: wr.dir_wr <= 1'b1;
            stepper_pkg::cmd_motor_enable:     enable <= rx.hdr.payload[motor_count-1:0];
            stepper_pkg::cmd_clk_divisor:      clock_divisor <= rx.hdr.payload[7:0];
            stepper_pkg::cmd_api_version: begin
              word_send_data <= {32'd0,
                                 stepper_pkg::version_devel,
                                 stepper_pkg::version_major,
                                 stepper_pkg::version_minor,
                                 stepper_pkg::version_patch};
            end
            default: ;
          endcase
        end else if (message_header == stepper_pkg::cmd_coordinated_step) begin
          message_word_count <= message_word_count + 8'd1;
          if (message_word_count == 8'd1)
            wr.dur_wr <= 1'b1;
          else if (!message_word_count[0])
            wr.inc_wr <= 1'b1;
          else
            wr.incinc_wr <= 1'b1;

          // Last incinc completes the move
          if (message_word_count == 8'(last_word)) begin
            wr.commit          <= 1'b1;
            message_header     <= '0;
            message_word_count <= '0;
          end
        end else begin
          message_header     <= '0; // Continuation word after version
          message_word_count <= '0;
        end
      end
    end
  end

  a_word_count_bound: assert property (@(posedge CLK) disable iff (resetn)
    message_word_count <= 8'(last_word))
    else $error("word count ran past the end of a coordinated step");

endmodule

//--- src/move_buffer.sv
module move_buffer #(
  parameter int motor_count        = 2,
  parameter int move_duration_bits = 32
) (
  input  logic      CLK,
  input  logic      resetn,
  move_wr_if.buffer wr,
  move_rd_if.buffer rd,
  output logic      buffer_dtr
);

  logic [motor_count-1:0]        dir_mem [2];
  logic [move_duration_bits-1:0] dur_mem [2];
  stepper_pkg::dda_word_t        inc_mem    [2][motor_count];
  stepper_pkg::dda_word_t        incinc_mem [2][motor_count];

  logic       wr_slot;
  logic [1:0] wr_flag; // Toggled by commit
  logic [1:0] rd_flag; // Toggled by release
  logic [1:0] pending;

  assign pending    = wr_flag ^ rd_flag;
  assign buffer_dtr = ~&pending; // Room for at least one more move

  // Slot contents
  always_ff @(posedge CLK) begin
    if (wr.dir_wr)
      dir_mem[wr_slot] <= wr.wdata[motor_count-1:0];
    if (wr.dur_wr)
      dur_mem[wr_slot] <= wr.wdata[move_duration_bits-1:0];
    for (int k = 0; k < motor_count; k++) begin
      if (wr.inc_wr && wr.axis == 8'(k))
        inc_mem[wr_slot][k] <= wr.wdata;
      if (wr.incinc_wr && wr.axis == 8'(k))
        incinc_mem[wr_slot][k] <= wr.wdata;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_slot <= 1'b0;
      wr_flag <= 2'b00;
      rd_flag <= 2'b00;
    end else begin
      if (wr.commit) begin
        wr_flag[wr_slot] <= ~wr_flag[wr_slot];
        wr_slot          <= ~wr_slot;
      end
      if (rd.slot_release)
        rd_flag[rd.rd_slot] <= ~rd_flag[rd.rd_slot];
    end
  end

  assign rd.pending  = pending;
  assign rd.duration = dur_mem[rd.rd_slot];
  assign rd.dir      = dir_mem[rd.rd_slot];

  always_comb begin
    for (int k = 0; k < motor_count; k++) begin
      rd.increment[k] = inc_mem[rd.rd_slot][k];
      rd.incinc[k]    = incinc_mem[rd.rd_slot][k];
    end
  end

  // Host must wait for buffer_dtr before a new move
  a_no_overwrite: assert property (@(posedge CLK) disable iff (resetn)
    wr.commit |-> !pending[wr_slot])
    else $error("move committed into a slot the DDA side still owns");

endmodule

//--- motion/dda_tick_gen.sv
module dda_tick_gen (
  input  logic       CLK,
  input  logic       resetn,
  input  logic [7:0] clock_divisor,
  output logic       tick
);

  logic [7:0] count;
  logic [7:0] reload;

  assign reload = (clock_divisor < 8'd2) ? 8'd2 : clock_divisor; // Minimum period of 2

  always_ff @(posedge CLK) begin
    if (resetn) begin
      count <= 8'd0;
      tick  <= 1'b0;
    end else if (count == 8'd0) begin
      count <= reload - 8'd1; // Divisor is picked up only here
      tick  <= 1'b1;
    end else begin
      count <= count - 8'd1;
      tick  <= 1'b0;
    end
  end

endmodule

//--- motion/dda_fsm.sv
module dda_fsm #(
  parameter int move_duration_bits = 32
) (
  input  logic         CLK,
  input  logic         resetn,
  input  logic         tick,
  output logic         loading_move,
  output logic         executing_move,
  output logic         move_done,
  move_rd_if.sequencer rd
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_load = 2'd1;
  localparam logic [1:0] st_exec = 2'd2;

  logic [1:0]                    state;
  logic [move_duration_bits-1:0] tick_count;
  logic [move_duration_bits-1:0] next_count;
  logic [move_duration_bits-1:0] target;
  logic                          move_end;

  assign target     = (rd.duration == '0) ? move_duration_bits'(1) : rd.duration;
  assign next_count = tick_count + move_duration_bits'(1);

  assign loading_move   = (state == st_load);
  assign executing_move = (state == st_exec);

  // Last tick of the move
  assign move_end        = executing_move && tick && (next_count == target);
  assign move_done       = move_end;
  assign rd.slot_release = move_end; // Frees the slot before rd_slot flips

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state      <= st_idle;
      tick_count <= '0;
      rd.rd_slot <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (rd.pending[rd.rd_slot])
            state <= st_load;
        end
        st_load: begin
          tick_count <= '0; // Timers latch their increments this cycle
          state      <= st_exec;
        end
        st_exec: begin
          if (move_end) begin
            rd.rd_slot <= ~rd.rd_slot;
            state      <= st_idle;
          end else if (tick) begin
            tick_count <= next_count;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // The slot being run stays owned by the DDA side until its release
  a_active_slot_pending: assert property (@(posedge CLK) disable iff (resetn)
    (loading_move || executing_move) |-> rd.pending[rd.rd_slot])
    else $error("move is running from a slot that is not pending");

endmodule

//--- motion/dda_timer.sv
module dda_timer #(
  parameter int axis_index = 0
) (
  input  logic      CLK,
  input  logic      resetn,
  input  logic      tick,
  input  logic      loading_move,
  input  logic      executing_move,
  output logic      step,
  move_rd_if.timer  rd
);

  // One whole step in 32.32 fixed point
  localparam stepper_pkg::dda_word_t step_unit = 64'sh0000_0001_0000_0000;

  stepper_pkg::dda_word_t acc;
  stepper_pkg::dda_word_t acc_next;
  stepper_pkg::dda_word_t inc;
  stepper_pkg::dda_word_t incinc;
  logic                   overflow;

  assign acc_next = acc + inc;
  assign overflow = (acc_next >= step_unit); // Negative sums never get here

  assign step = executing_move && tick && overflow; // Same cycle as the tick

  always_ff @(posedge CLK) begin
    if (resetn) begin
      acc    <= '0;
      inc    <= '0;
      incinc <= '0;
    end else if (loading_move) begin
      acc    <= '0;
      inc    <= rd.increment[axis_index];
      incinc <= rd.incinc[axis_index];
    end else if (executing_move && tick) begin
      inc <= inc + incinc; // Second order, speed ramps per tick
      if (overflow)
        acc <= acc_next - step_unit;
      else
        acc <= acc_next;
    end
  end

endmodule

//--- src/stepper_ctrl_top.sv
module stepper_ctrl_top #(
  parameter int motor_count        = 2,
  parameter int move_duration_bits = 32
) (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic [63:0]            word_data_received,
  input  logic                   word_received,
  output logic [63:0]            word_send_data,
  output logic                   buffer_dtr,
  output logic                   move_done,
  output logic [motor_count-1:0] step,
  output logic [motor_count-1:0] dir,
  output logic [motor_count-1:0] enable
);

  logic [7:0] clock_divisor;
  logic       tick;
  logic       loading_move;
  logic       executing_move;

  move_wr_if wr_if ();
  move_rd_if #(
    .motor_count        (motor_count),
    .move_duration_bits (move_duration_bits)
  ) rd_if ();

  assign dir = rd_if.dir; // Direction of the move being run

  spi_cmd_decoder #(.motor_count(motor_count)) decoder_i (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .enable             (enable),
    .clock_divisor      (clock_divisor),
    .wr                 (wr_if.decoder)
  );

  move_buffer #(
    .motor_count        (motor_count),
    .move_duration_bits (move_duration_bits)
  ) buffer_i (
    .CLK        (CLK),
    .resetn     (resetn),
    .wr         (wr_if.buffer),
    .rd         (rd_if.buffer),
    .buffer_dtr (buffer_dtr)
  );

  dda_tick_gen tick_gen_i (
    .CLK           (CLK),
    .resetn        (resetn),
    .clock_divisor (clock_divisor),
    .tick          (tick)
  );

  dda_fsm #(.move_duration_bits(move_duration_bits)) fsm_i (
    .CLK            (CLK),
    .resetn         (resetn),
    .tick           (tick),
    .loading_move   (loading_move),
    .executing_move (executing_move),
    .move_done      (move_done),
    .rd             (rd_if.sequencer)
  );

  for (genvar i = 0; i < motor_count; i++) begin : g_axis
    dda_timer #(.axis_index(i)) timer_i (
      .CLK            (CLK),
      .resetn         (resetn),
      .tick           (tick),
      .loading_move   (loading_move),
      .executing_move (executing_move),
      .step           (step[i]),
      .rd             (rd_if.timer)
    );
  end

endmodule

//--- tb/tb_stepper_ctrl.sv
module tb_stepper_ctrl;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int motor_count = 2;
  localparam int default_div = 40;
  localparam int fast_div    = 5;  // Divisor for the timing and queue tests
  localparam int single_dur  = 12;
  localparam int div_dur     = 10;
  localparam int queued_dur  = 20;
  localparam longint step_unit = 64'sh0000_0001_0000_0000;

  // Move ticks times divisor, plus room for word traffic and idle waits
  localparam int cycle_limit = single_dur * default_div + div_dur * fast_div +
                               2 * queued_dur * fast_div + 600;

  logic                   CLK;
  logic                   resetn;
  logic [63:0]            word_data_received;
  logic                   word_received;
  logic [63:0]            word_send_data;
  logic                   buffer_dtr;
  logic                   move_done;
  logic [motor_count-1:0] step;
  logic [motor_count-1:0] dir;
  logic [motor_count-1:0] enable;

  int                     cycle_count = 0;
  int                     done_count;
  int                     done_cycle;       // Edge on which move_done was seen
  int                     word_start_cycle; // Edge before the latest word was raised
  logic [motor_count-1:0] last_done_dir;
  int                     step_count  [motor_count];
  int                     step_base   [motor_count];
  int                     move_expect [motor_count];
  int                     expect_steps [motor_count];
  logic [31:0]            lfsr_state;

  stepper_ctrl_top #(
    .motor_count        (motor_count),
    .move_duration_bits (32)
  ) dut_i (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .buffer_dtr         (buffer_dtr),
    .move_done          (move_done),
    .step               (step),
    .dir                (dir),
    .enable             (enable)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("TB FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // Step and move_done counters
  always @(posedge CLK) begin
    if (resetn) begin
      done_count <= 0;
      for (int k = 0; k < motor_count; k++)
        step_count[k] <= 0;
    end else begin
      for (int k = 0; k < motor_count; k++) begin
        if (step[k])
          step_count[k] <= step_count[k] + 1;
      end
      if (move_done) begin
        done_count    <= done_count + 1;
        done_cycle    <= cycle_count + 1;
        last_done_dir <= dir; // Slot index flips on this edge
      end
    end
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("TB FAILED");
      $fatal(1, "check on %s failed", name);
    end
  endtask

  // Galois LFSR stepped once per bit
  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] value;
    value = '0;
    for (int b = 0; b < n; b++) begin
      if (lfsr_state[0])
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      else
        lfsr_state = lfsr_state >> 1;
      value = {value[62:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Reference accumulator with one pass per tick
  function automatic int model_steps(input longint inc, input longint incinc,
                                     input int duration);
    longint acc;
    longint cur;
    int     ticks;
    int     steps;
    acc   = 0;
    cur   = inc;
    steps = 0;
    ticks = (duration == 0) ? 1 : duration;
    for (int t = 0; t < ticks; t++) begin
      acc = acc + cur;
      if (acc >= step_unit) begin
        steps++;
        acc = acc - step_unit;
      end
      cur = cur + incinc;
    end
    return steps;
  endfunction

  function automatic logic [63:0] header_word(input logic [7:0] cmd, input logic [47:0] payload);
    return {cmd, 8'h00, payload}; // Axis byte left zero
  endfunction

  task automatic send_word(input logic [63:0] data, output logic [63:0] reply);
    word_start_cycle   = cycle_count;
    word_data_received = data;
    word_received      = 1'b1;
    repeat (2) @(posedge CLK);
    #1;
    reply         = word_send_data; // Word was acted on at the second edge
    word_received = 1'b0;
    repeat (2) @(posedge CLK);
    #1;
  endtask

  task automatic send_checked(input logic [63:0] data, input logic [63:0] expected_reply);
    logic [63:0] reply;
    send_word(data, reply);
    check_value("word_send_data", reply, expected_reply);
  endtask

  task automatic wait_for_room();
    while (!buffer_dtr) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic wait_done(input int target);
    while (done_count < target) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic snapshot_steps();
    for (int k = 0; k < motor_count; k++)
      step_base[k] = step_count[k];
  endtask

  task automatic check_step_counts();
    for (int k = 0; k < motor_count; k++)
      check_value($sformatf("step count axis %0d", k),
                  64'(step_count[k] - step_base[k]), 64'(expect_steps[k]));
  endtask

  task automatic check_latency(input int lo, input int hi);
    int latency;
    latency = done_cycle - word_start_cycle;
    if (latency < lo || latency > hi)
      $display("Move took %0d cycles, bounds %0d to %0d", latency, lo, hi);
    check_value("move latency within bounds", 64'(latency >= lo && latency <= hi), 64'd1);
  endtask

  // Random move whose replies must all be zero
  task automatic send_move(input logic [motor_count-1:0] dirs, input int duration);
    longint inc;
    longint incinc;
    wait_for_room();
    send_checked(header_word(stepper_pkg::cmd_coordinated_step, 48'(dirs)), 64'd0);
    send_checked(64'(duration), 64'd0);
    for (int k = 0; k < motor_count; k++) begin
      inc            = longint'(random_bits(31));
      incinc         = longint'(random_bits(12)); // Small, non-negative
      move_expect[k] = model_steps(inc, incinc, duration);
      send_checked(inc, 64'd0);
      send_checked(incinc, 64'd0);
    end
  endtask

  task automatic test_reset_values();
    check_value("step", 64'(step), 64'd0);
    check_value("enable", 64'(enable), 64'd0);
    check_value("move_done", 64'(move_done), 64'd0);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd1);
    check_value("word_send_data", word_send_data, 64'd0);
  endtask

  task automatic test_api_version();
    send_checked(header_word(stepper_pkg::cmd_api_version, 48'd0),
                 {32'd0, stepper_pkg::version_devel, stepper_pkg::version_major,
                  stepper_pkg::version_minor, stepper_pkg::version_patch});
    // Looks like an enable write but is only a continuation
    send_checked(header_word(stepper_pkg::cmd_motor_enable, 48'h3), 64'd0);
    check_value("enable", 64'(enable), 64'd0);
    send_checked(header_word(stepper_pkg::cmd_motor_enable, 48'h2), 64'd0);
    check_value("enable", 64'(enable), 64'h2);
  endtask

  task automatic test_single_move();
    int base_done;
    base_done = done_count;
    snapshot_steps();
    send_move(2'b01, single_dur);
    wait_done(base_done + 1);
    expect_steps = move_expect;
    check_step_counts();
    check_value("dir", 64'(last_done_dir), 64'h1);
    // Lower bound shows the divisor is still the default
    check_latency((single_dur - 1) * default_div, (single_dur + 1) * default_div + 6);
    repeat (50) @(posedge CLK);
    #1;
    check_value("move_done pulses", 64'(done_count - base_done), 64'd1);
  endtask

  task automatic test_clock_divisor();
    int base_done;
    send_checked(header_word(stepper_pkg::cmd_clk_divisor, 48'(fast_div)), 64'd0);
    repeat (default_div + 2) @(posedge CLK); // Old period runs out first
    #1;
    base_done = done_count;
    snapshot_steps();
    send_move(2'b10, div_dur);
    wait_done(base_done + 1);
    check_latency(div_dur * fast_div, (div_dur + 1) * fast_div + 6);
    expect_steps = move_expect;
    check_step_counts();
    check_value("dir", 64'(last_done_dir), 64'h2);
  endtask

  task automatic test_queued_moves();
    int base_done;
    int first_expect [motor_count];
    base_done = done_count;
    snapshot_steps();
    send_move(2'b11, queued_dur);
    first_expect = move_expect;
    send_move(2'b01, queued_dur);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd0); // Both slots full
    wait_done(base_done + 1);
    check_value("buffer_dtr", 64'(buffer_dtr), 64'd1);
    check_value("dir", 64'(last_done_dir), 64'h3);
    expect_steps = first_expect;
    check_step_counts();
    wait_done(base_done + 2);
    check_value("dir", 64'(last_done_dir), 64'h1);
    for (int k = 0; k < motor_count; k++)
      expect_steps[k] = first_expect[k] + move_expect[k];
    check_step_counts();
    repeat (20) @(posedge CLK);
    #1;
    check_value("move_done pulses", 64'(done_count - base_done), 64'd2);
  endtask

  initial begin
    resetn             = 1'b1; // Reset asserted
    word_received      = 1'b0;
    word_data_received = '0;
    lfsr_state         = 32'hc448;
    repeat (2) @(posedge CLK);
    #1;
    resetn = 1'b0;
    test_reset_values();
    test_api_version();
    test_single_move();
    test_clock_divisor();
    test_queued_moves();
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- project.f
common/stepper_pkg.sv
common/move_wr_if.sv
common/move_rd_if.sv
src/spi_cmd_decoder.sv
src/move_buffer.sv
motion/dda_tick_gen.sv
motion/dda_fsm.sv
motion/dda_timer.sv
src/stepper_ctrl_top.sv
tb/tb_stepper_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the stepper controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_stepper_ctrl -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^TB PASSED$"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
